// File: tests/program_trace.txt
# I byte-address word | W reg value (next retired write) | R reg value (final contents)
# all numbers are hex
I 00000000 24000005
I 00000004 2401fffd
I 00000008 34028001
I 0000000c 3c031234
I 00000010 00622021
I 00000014 00812823
I 00000018 00853024
I 0000001c 00223825
I 00000020 0022402a
I 00000024 00025100
I 00000028 10270002
I 0000002c 240b0011
I 00000030 240c0066
I 00000034 15080004
I 00000038 240c0022
I 0000003c 0c000018
I 00000040 240d0033
I 00000044 240e0044
I 00000048 08000012
I 00000060 03e07821
I 00000064 03e00008
I 00000068 24100055
I 0000006c 24110077
W 01 fffffffd
W 02 00008001
W 03 12340000
W 04 12348001
W 05 12348004
W 06 12348000
W 07 fffffffd
W 08 00000001
W 0a 00080010
W 0b 00000011
W 0c 00000022
W 1f 00000044
W 0d 00000033
W 0f 00000044
W 10 00000055
W 0e 00000044
R 00 00000000
R 0c 00000022
R 11 00000000
R 1f 00000044
R 0e 00000044

// File: list.f
src/coreTypes.sv
src/fetchUnit.sv
src/regFile.sv
src/decodeStage.sv
src/executeStage.sv
src/resultStage.sv
src/pipeCore.sv
tests/pipeCoreTb.sv

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module pipeCoreTb -f list.f -o pipeCoreSim > build.log 2>&1
if [ $? -ne 0 ]; then
    cat build.log
    echo "build failed"
    exit 1
fi

./obj_dir/pipeCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

grep -q "ALL CHECKS PASSED" sim.log || exit 1
exit 0

// File: tests/pipeCoreTb.sv
module pipeCoreTb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] resetPc = 32'h0000_0000;
    localparam int timeoutCycles = 500;

    logic        clk;
    logic        rstN = 1'b0;
    logic [31:0] pc;
    logic [31:0] instr;
    logic [4:0]  debugAddr = 5'd0;
    logic [31:0] debugData;
    logic        retireValid;
    logic [4:0]  retireAddr;
    logic [31:0] retireData;

    logic [31:0] imem [256];
    logic [4:0]  expDest[$];
    logic [31:0] expData[$];
    logic [4:0]  finalReg[$];
    logic [31:0] finalData[$];
    int          retireIdx = 0;
    int          passCount = 0;
    int          failCount = 0;
    logic        zeroFailed = 1'b0;

    pipeCore #(.resetPc(resetPc)) dut0 (
        .clk, .rstN, .pc, .instr, .debugAddr, .debugData,
        .retireValid, .retireAddr, .retireData
    );

    // instruction memory answers in the same cycle
    assign instr = imem[pc[9:2]];

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic loadTrace();
        int          fd;
        int          fields;
        string       line;
        logic [7:0]  kind;
        logic [31:0] first;
        logic [31:0] second;
        // unused words carry an undefined opcode, so they act as no-ops
        for (int i = 0; i < 256; i++) begin
            imem[i] = {6'h3f, 26'(i)};
        end
        fd = $fopen("tests/program_trace.txt", "r");
        if (fd == 0) begin
            failCount++;
            $display("could not open tests/program_trace.txt for reading");
            return;
        end
        while ($fgets(line, fd) != 0) begin
            fields = $sscanf(line, "%c %h %h", kind, first, second);
            if (fields == 3) begin
                case (kind)
                    "I": imem[first[9:2]] = second;
                    "W": begin
                        expDest.push_back(first[4:0]);
                        expData.push_back(second);
                    end
                    "R": begin
                        finalReg.push_back(first[4:0]);
                        finalData.push_back(second);
                    end
                endcase
            end
        end
        $fclose(fd);
    endtask

    task automatic checkValue(input string name, input logic [31:0] expected,
                              input logic [31:0] actual);
        assert (actual === expected) begin
            passCount++;
            $display("ok    %s = %h", name, actual);
        end else begin
            failCount++;
            $display("Error %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // one clock of monitoring for $zero on the debug port and for the retire report
    task automatic sampleCycle();
        @(negedge clk);
        if (debugAddr == 5'd0 && !zeroFailed) begin
            assert (debugData === 32'd0) else begin
                zeroFailed = 1'b1;
                failCount++;
                $display("Error zero register expected %h actual %h", 32'd0, debugData);
            end
        end
        if (retireValid) begin
            if (retireIdx < expDest.size()) begin
                checkValue($sformatf("retire %0d dest", retireIdx),
                           {27'd0, expDest[retireIdx]}, {27'd0, retireAddr});
                checkValue($sformatf("retire %0d data", retireIdx),
                           expData[retireIdx], retireData);
                retireIdx++;
            end else begin
                failCount++;
                $display("unexpected retired write to r%0d after the expected sequence",
                         retireAddr);
            end
        end
    endtask

    task automatic waitForRetires();
        int cycles;
        cycles = 0;
        while (retireIdx < expDest.size() && cycles < timeoutCycles) begin
            sampleCycle();
            cycles++;
        end
        if (retireIdx < expDest.size()) begin
            failCount++;
            $display("timeout: wait for retired writes expired after %0d cycles, %0d of %0d seen",
                     cycles, retireIdx, expDest.size());
        end
    endtask

    task automatic readFinalRegisters();
        for (int i = 0; i < finalReg.size(); i++) begin
            @(posedge clk);
            debugAddr <= finalReg[i];
            sampleCycle();
            checkValue($sformatf("final r%0d", finalReg[i]), finalData[i], debugData);
        end
    endtask

    initial begin
        loadTrace();
        repeat (2) @(posedge clk);
        rstN <= 1'b1;
        @(negedge clk);
        checkValue("reset pc", resetPc, pc);
        checkValue("reset retireValid", 32'd0, {31'd0, retireValid});
        waitForRetires();
        readFinalRegisters();
        $display("%0d checks passed, %0d failed", passCount, failCount);
        if (failCount == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

endmodule

// File: src/pipeCore.sv
module pipeCore #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic        clk,
    input  logic        rstN,
    output logic [31:0] pc,
    input  logic [31:0] instr,
    input  logic [4:0]  debugAddr,
    output logic [31:0] debugData,
    output logic        retireValid,
    output logic [4:0]  retireAddr,
    output logic [31:0] retireData
);
    import coreTypes::*;

    instrWord    idInstr;
    logic [31:0] idPc, redirectPc;
    logic        redirect;
    logic [4:0]  rsAddr, rtAddr;
    logic [31:0] rsData, rtData;
    logic        exValid, exWrite;
    aluOp        exOp;
    logic [31:0] exA, exB;
    logic [4:0]  exShamt, exDest;
    logic [31:0] aluResult;
    logic        exFwdWrite;
    logic [4:0]  exFwdDest;
    // execute/result register, then its copy at the write port
    logic        resWrite, rfWrite;
    logic [4:0]  resDest, rfDest;
    logic [31:0] resData, rfData;

    fetchUnit #(.resetPc(resetPc)) fetch0 (
        .clk, .rstN, .redirect, .redirectPc, .instr, .pc, .idInstr, .idPc
    );

    regFile regs0 (
        .clk, .rstN, .rsAddr, .rtAddr, .debugAddr, .rsData, .rtData, .debugData,
        .wbWrite(rfWrite), .wbDest(rfDest), .wbData(rfData)
    );

    decodeStage decode0 (
        .clk, .rstN, .idInstr, .idPc, .rsData, .rtData,
        .aluResult, .exFwdWrite, .exFwdDest,
        .wbWrite(rfWrite), .wbDest(rfDest), .wbData(rfData),
        .rsAddr, .rtAddr, .redirect, .redirectPc,
        .exValid, .exOp, .exA, .exB, .exShamt, .exWrite, .exDest
    );

    executeStage execute0 (
        .clk, .rstN, .exValid, .exOp, .exA, .exB, .exShamt, .exWrite, .exDest,
        .aluResult, .exFwdWrite, .exFwdDest,
        .wbWrite(resWrite), .wbDest(resDest), .wbData(resData)
    );

    resultStage result0 (
        .clk, .rstN,
        .wbWrite(resWrite), .wbDest(resDest), .wbData(resData),
        .wbWriteOut(rfWrite), .wbDestOut(rfDest), .wbDataOut(rfData),
        .retireValid, .retireAddr, .retireData
    );

endmodule

// File: src/resultStage.sv
module resultStage (
    input  logic        clk,
    input  logic        rstN,
    input  logic        wbWrite,
    input  logic [4:0]  wbDest,
    input  logic [31:0] wbData,
    output logic        wbWriteOut,
    output logic [4:0]  wbDestOut,
    output logic [31:0] wbDataOut,
    output logic        retireValid,
    output logic [4:0]  retireAddr,
    output logic [31:0] retireData
);

    logic [31:0] retireCount;

    // write port and retire report see the same result register
    assign wbWriteOut  = wbWrite;
    assign wbDestOut   = wbDest;
    assign wbDataOut   = wbData;
    assign retireValid = wbWrite;
    assign retireAddr  = wbDest;
    assign retireData  = wbData;

    // retired writes since reset
    always_ff @(posedge clk) begin
        if (!rstN) begin
            retireCount <= 32'd0;
        end else if (wbWrite) begin
            retireCount <= retireCount + 32'd1;
        end
    end

    retireKnown: assert property (@(posedge clk) disable iff (!rstN)
        retireValid |-> !$isunknown({retireCount, retireAddr, retireData}))
        else $error("retire %0d carries an unknown value", retireCount);

endmodule

// File: src/executeStage.sv
module executeStage (
    input  logic            clk,
    input  logic            rstN,
    input  logic            exValid,
    input  coreTypes::aluOp exOp,
    input  logic [31:0]     exA,
    input  logic [31:0]     exB,
    input  logic [4:0]      exShamt,
    input  logic            exWrite,
    input  logic [4:0]      exDest,
    output logic [31:0]     aluResult,
    output logic            exFwdWrite,
    output logic [4:0]      exFwdDest,
    output logic            wbWrite,
    output logic [4:0]      wbDest,
    output logic [31:0]     wbData
);
    import coreTypes::*;

    always_comb begin
        case (exOp)
            aluAdd:  aluResult = exA + exB;
            aluSub:  aluResult = exA - exB;
            aluAnd:  aluResult = exA & exB;
            aluOr:   aluResult = exA | exB;
            aluSlt:  aluResult = {31'd0, $signed(exA) < $signed(exB)};
            aluSll:  aluResult = exA << exShamt;
            // immediate arrives zero extended in exB
            aluLui:  aluResult = exB << 16;
            default: aluResult = 32'd0;
        endcase
    end

    // forwarding source for the instruction now in decode
    assign exFwdWrite = exValid && exWrite;
    assign exFwdDest  = exDest;

    always_ff @(posedge clk) begin
        if (!rstN) begin
            wbWrite <= 1'b0;
        end else begin
            wbWrite <= exValid && exWrite;
        end
    end

    always_ff @(posedge clk) begin
        wbDest <= exDest;
        wbData <= aluResult;
    end

endmodule

// File: src/decodeStage.sv
module decodeStage (
    input  logic                clk,
    input  logic                rstN,
    input  coreTypes::instrWord idInstr,
    input  logic [31:0]         idPc,
    input  logic [31:0]         rsData,
    input  logic [31:0]         rtData,
    input  logic [31:0]         aluResult,
    input  logic                exFwdWrite,
    input  logic [4:0]          exFwdDest,
    input  logic                wbWrite,
    input  logic [4:0]          wbDest,
    input  logic [31:0]         wbData,
    output logic [4:0]          rsAddr,
    output logic [4:0]          rtAddr,
    output logic                redirect,
    output logic [31:0]         redirectPc,
    output logic                exValid,
    output coreTypes::aluOp     exOp,
    output logic [31:0]         exA,
    output logic [31:0]         exB,
    output logic [4:0]          exShamt,
    output logic                exWrite,
    output logic [4:0]          exDest
);
    import coreTypes::*;

    logic [31:0] fwdRs, fwdRt;
    logic [31:0] immSext, immZext;
    logic [31:0] pcPlus4, branchTarget, jumpTarget;
    logic        knownOp, nextWrite;
    aluOp        nextOp;
    logic [31:0] nextA, nextB;
    logic [4:0]  nextShamt, nextDest;

    // execute result wins over the result stage
    function automatic logic [31:0] fwdSelect(
        input logic [4:0]  addr,
        input logic [31:0] regData,
        input logic        exW,
        input logic [4:0]  exD,
        input logic [31:0] exV,
        input logic        wbW,
        input logic [4:0]  wbD,
        input logic [31:0] wbV
    );
        logic [31:0] value;
        value = regData;
        if (addr != 5'd0) begin
            if (exW && exD == addr) begin
                value = exV;
            end else if (wbW && wbD == addr) begin
                value = wbV;
            end
        end
        return value;
    endfunction

    assign rsAddr = idInstr.rType.rs;
    assign rtAddr = idInstr.rType.rt;
    assign fwdRs  = fwdSelect(rsAddr, rsData, exFwdWrite, exFwdDest, aluResult,
                              wbWrite, wbDest, wbData);
    assign fwdRt  = fwdSelect(rtAddr, rtData, exFwdWrite, exFwdDest, aluResult,
                              wbWrite, wbDest, wbData);

    assign immSext      = {{16{idInstr.iType.imm[15]}}, idInstr.iType.imm};
    assign immZext      = {16'd0, idInstr.iType.imm};
    assign pcPlus4      = idPc + 32'd4;
    assign branchTarget = pcPlus4 + {immSext[29:0], 2'b00};
    assign jumpTarget   = {pcPlus4[31:28], idInstr.jType.target, 2'b00};

    always_comb begin
        nextOp     = aluAdd;
        nextA      = fwdRs;
        nextB      = fwdRt;
        nextShamt  = 5'd0;
        nextDest   = idInstr.rType.rd;
        nextWrite  = 1'b0;
        knownOp    = 1'b1;
        redirect   = 1'b0;
        redirectPc = branchTarget;
        case (idInstr.rType.opcode)
            opSpecial: begin
                nextWrite = 1'b1;
                case (idInstr.rType.funct)
                    fnAddu: nextOp = aluAdd;
                    fnSubu: nextOp = aluSub;
                    fnAnd:  nextOp = aluAnd;
                    fnOr:   nextOp = aluOr;
                    fnSlt:  nextOp = aluSlt;
                    fnSll: begin
                        nextOp    = aluSll;
                        nextA     = fwdRt;
                        nextShamt = idInstr.rType.shamt;
                    end
                    fnJr: begin
                        nextWrite  = 1'b0;
                        redirect   = 1'b1;
                        redirectPc = fwdRs;
                    end
                    default: begin
                        nextWrite = 1'b0;
                        knownOp   = 1'b0;
                    end
                endcase
            end
            opAddiu, opOri, opLui: begin
                nextWrite = 1'b1;
                nextDest  = idInstr.iType.rt;
                nextB     = (idInstr.iType.opcode == opAddiu) ? immSext : immZext;
                if (idInstr.iType.opcode == opOri) begin
                    nextOp = aluOr;
                end else if (idInstr.iType.opcode == opLui) begin
                    nextOp = aluLui;
                end
            end
            opBeq: redirect = (fwdRs == fwdRt);
            opBne: redirect = (fwdRs != fwdRt);
            opJ: begin
                redirect   = 1'b1;
                redirectPc = jumpTarget;
            end
            opJal: begin
                redirect   = 1'b1;
                redirectPc = jumpTarget;
                nextWrite  = 1'b1;
                nextDest   = linkReg;
                // link past the delay slot
                nextA      = idPc + 32'd8;
                nextB      = 32'd0;
            end
            default: knownOp = 1'b0;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstN) begin
            exValid <= 1'b0;
            exWrite <= 1'b0;
        end else begin
            exValid <= knownOp;
            exWrite <= nextWrite && (nextDest != 5'd0);
        end
    end

    always_ff @(posedge clk) begin
        exOp    <= nextOp;
        exA     <= nextA;
        exB     <= nextB;
        exShamt <= nextShamt;
        exDest  <= nextDest;
    end

    // a redirect needs a decoded op and a defined target
    noBranchOnUnknown: assert property (@(posedge clk) disable iff (!rstN)
        redirect |-> knownOp && !$isunknown(redirectPc))
        else $error("redirect at pc %h lacks a decoded op or a known target", idPc);

endmodule

// File: src/regFile.sv
module regFile (
    input  logic        clk,
    input  logic        rstN,
    input  logic [4:0]  rsAddr,
    input  logic [4:0]  rtAddr,
    input  logic [4:0]  debugAddr,
    output logic [31:0] rsData,
    output logic [31:0] rtData,
    output logic [31:0] debugData,
    input  logic        wbWrite,
    input  logic [4:0]  wbDest,
    input  logic [31:0] wbData
);

    logic [31:0] regs [32];

    always_ff @(posedge clk) begin
        if (!rstN) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wbWrite && wbDest != 5'd0) begin
            regs[wbDest] <= wbData;
        end
    end

    // $zero is hardwired on every read port
    assign rsData    = (rsAddr == 5'd0) ? 32'd0 : regs[rsAddr];
    assign rtData    = (rtAddr == 5'd0) ? 32'd0 : regs[rtAddr];
    assign debugData = (debugAddr == 5'd0) ? 32'd0 : regs[debugAddr];

    // decode drops writes to $zero two cycles earlier
    noZeroWrite: assert property (@(posedge clk) disable iff (!rstN)
        wbWrite |-> wbDest != 5'd0)
        else $error("write-back targets register zero");

endmodule

// File: src/fetchUnit.sv
module fetchUnit #(
    parameter logic [31:0] resetPc = 32'h0000_0000
) (
    input  logic                 clk,
    input  logic                 rstN,
    input  logic                 redirect,
    input  logic [31:0]          redirectPc,
    input  logic [31:0]          instr,
    output logic [31:0]          pc,
    output coreTypes::instrWord  idInstr,
    output logic [31:0]          idPc
);

    // pc and the word held in decode
    always_ff @(posedge clk) begin
        if (!rstN) begin
            pc      <= resetPc;
            idInstr <= '0;
        end else begin
            pc      <= redirect ? redirectPc : pc + 32'd4;
            idInstr <= instr;
        end
    end

    // address travels with its word
    always_ff @(posedge clk) begin
        idPc <= pc;
    end

    // jr targets come from registers, so misalignment is possible
    pcAligned: assert property (@(posedge clk) disable iff (!rstN)
        pc[1:0] == 2'b00)
        else $error("fetch pc %h is not word aligned", pc);

endmodule

// File: src/coreTypes.sv
package coreTypes;

    // one fetched word, read through three field layouts
    typedef union packed {
        struct packed {
            logic [5:0] opcode;
            logic [4:0] rs;
            logic [4:0] rt;
            logic [4:0] rd;
            logic [4:0] shamt;
            logic [5:0] funct;
        } rType;
        struct packed {
            logic [5:0]  opcode;
            logic [4:0]  rs;
            logic [4:0]  rt;
            logic [15:0] imm;
        } iType;
        struct packed {
            logic [5:0]  opcode;
            logic [25:0] target;
        } jType;
    } instrWord;

    typedef enum logic [3:0] {
        aluAdd,
        aluSub,
        aluAnd,
        aluOr,
        aluSlt,
        aluSll,
        aluLui
    } aluOp;

    // primary opcodes
    localparam logic [5:0] opSpecial = 6'h00;
    localparam logic [5:0] opJ       = 6'h02;
    localparam logic [5:0] opJal     = 6'h03;
    localparam logic [5:0] opBeq     = 6'h04;
    localparam logic [5:0] opBne     = 6'h05;
    localparam logic [5:0] opAddiu   = 6'h09;
    localparam logic [5:0] opOri     = 6'h0d;
    localparam logic [5:0] opLui     = 6'h0f;

    // funct field of special opcode
    localparam logic [5:0] fnSll  = 6'h00;
    localparam logic [5:0] fnJr   = 6'h08;
    localparam logic [5:0] fnAddu = 6'h21;
    localparam logic [5:0] fnSubu = 6'h23;
    localparam logic [5:0] fnAnd  = 6'h24;
    localparam logic [5:0] fnOr   = 6'h25;
    localparam logic [5:0] fnSlt  = 6'h2a;

    // return address register for jal
    localparam logic [4:0] linkReg = 5'd31;

endpackage
